// File: logic/adc_pkg.sv
// converter frame geometry, byte type and serial bit counter sizing
package adc_pkg;

    // one conversion frame as read out of the converter
    localparam int FRAME_BYTES = 32;

    // width of one byte on the serial line
    localparam int BYTE_W = 8;

    // byte address inside the frame buffer
    localparam int BYTE_ADDR_W = 5;

    // bit position counter inside one byte on the serial line
    localparam int BIT_CNT_W = $clog2(BYTE_W);

    // the serial line runs MSB first, so the first bit lands in the top position
    typedef logic [BYTE_W-1:0] adc_byte_t;

    // byte address type of the buffer write side
    typedef logic [BYTE_ADDR_W-1:0] adc_addr_t;

    // frame position counter of the SPI reader
    typedef logic [BYTE_ADDR_W-1:0] byte_cnt_t;

    // bit position counter of the SPI reader
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

// File: logic/host_pkg.sv
// host read port word geometry and word and address types
package host_pkg;

    // bytes packed into one host word with the first byte in the top position
    localparam int WORD_BYTES = 4;

    // host read word width
    localparam int WORD_W = 32;

    // word address width for a frame that is eight words deep
    localparam int WORD_ADDR_W = 3;

    // a word as returned on the read port
    typedef logic [WORD_W-1:0] host_word_t;

    // a word address as presented on the read port
    typedef logic [WORD_ADDR_W-1:0] host_addr_t;

endpackage

// File: logic/conv_trigger.sv
// conversion trigger that merges the host trigger pulse with a periodic trigger timer
`timescale 1ns/1ps

module conv_trigger #(
    parameter int TRIGGER_PERIOD = 700
) (
    input  logic clk,
    input  logic resetn,
    input  logic trigger,
    input  logic periodic,
    output logic start
);

    localparam int CNT_W = $clog2(TRIGGER_PERIOD + 1);

    logic [CNT_W-1:0] period_cnt;
    logic             period_end;
    logic             trigger_q;
    logic             tick_q;

    assign period_end = (period_cnt == CNT_W'(TRIGGER_PERIOD - 1));

    // the count is held at zero while periodic is low, so each rise restarts the timer
    always_ff @(posedge clk) begin
        if (!resetn) begin
            period_cnt <= '0;
            tick_q     <= 1'b0;
            trigger_q  <= 1'b0;
        end else begin
            trigger_q <= trigger;
            tick_q    <= periodic && period_end;
            if (!periodic || period_end) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // both sources are registered, so either one gives the same one-cycle pulse
    assign start = trigger_q | tick_q;

endmodule

// File: logic/adc_spi_reader.sv
// SPI master that reads one converter frame MSB first and strobes each byte
`timescale 1ns/1ps

module adc_spi_reader #(
    parameter int SCLK_DIV = 2
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               start,
    output logic               cs_n,
    output logic               sclk,
    input  logic               sdi,
    output logic               frame_start,
    output logic               byte_valid,
    output adc_pkg::adc_byte_t byte_data
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_STOP
    } state_t;

    state_t             state;
    logic [DIV_W-1:0]   div_cnt;
    adc_pkg::bit_cnt_t  bit_cnt;
    adc_pkg::byte_cnt_t byte_cnt;
    adc_pkg::adc_byte_t shift_q;
    logic               half_done;
    logic               sample_bit;
    logic               last_bit;
    logic               last_byte;

    assign half_done  = (div_cnt == DIV_W'(SCLK_DIV - 1));
    // sclk is about to rise, which is where the converter output is stable
    assign sample_bit = (state == ST_SHIFT) && half_done && !sclk;
    assign last_bit   = (bit_cnt == adc_pkg::bit_cnt_t'(adc_pkg::BYTE_W - 1));
    assign last_byte  = (byte_cnt == adc_pkg::byte_cnt_t'(adc_pkg::FRAME_BYTES - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= ST_IDLE;
            cs_n        <= 1'b1;
            sclk        <= 1'b1;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            frame_start <= 1'b0;
            byte_valid  <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            byte_valid  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // a start that arrives in any other state is dropped
                    if (start) begin
                        state       <= ST_SHIFT;
                        cs_n        <= 1'b0;
                        frame_start <= 1'b1;
                        div_cnt     <= '0;
                        bit_cnt     <= '0;
                        byte_cnt    <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (half_done) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (sample_bit) begin
                        bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
                        if (last_bit) begin
                            byte_valid <= 1'b1;
                            byte_cnt   <= byte_cnt + 1'b1;
                            if (last_byte) begin
                                state <= ST_STOP;
                            end
                        end
                    end
                end
                default: begin
                    // one cycle after the final byte strobe, chip select is released
                    state <= ST_IDLE;
                    cs_n  <= 1'b1;
                end
            endcase
        end
    end

    // the shift register is complete in the cycle that byte_valid is high
    always_ff @(posedge clk) begin
        if (sample_bit) begin
            shift_q <= {shift_q[adc_pkg::BYTE_W-2:0], sdi};
        end
    end

    assign byte_data = shift_q;

endmodule

// File: logic/frame_buffer.sv
// byte-write, word-read frame memory with a frame-done pulse
`timescale 1ns/1ps

module frame_buffer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                frame_start,
    input  logic                byte_valid,
    input  adc_pkg::adc_byte_t  byte_data,
    output logic                drdy,
    input  logic                rd_en,
    input  host_pkg::host_addr_t rd_addr,
    output host_pkg::host_word_t rdata
);

    adc_pkg::adc_byte_t   mem [adc_pkg::FRAME_BYTES];
    adc_pkg::adc_addr_t   wr_addr;
    logic                 last_addr;
    host_pkg::host_word_t rd_word;

    assign last_addr = (wr_addr == adc_pkg::adc_addr_t'(adc_pkg::FRAME_BYTES - 1));

    // write address restarts with every accepted frame and wraps at the frame end
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_addr <= '0;
        end else if (frame_start) begin
            wr_addr <= '0;
        end else if (byte_valid) begin
            wr_addr <= last_addr ? '0 : wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            mem[wr_addr] <= byte_data;
        end
    end

    // frame is complete once the last byte has been written
    always_ff @(posedge clk) begin
        if (!resetn) begin
            drdy <= 1'b0;
        end else begin
            drdy <= byte_valid && last_addr;
        end
    end

    // the lowest byte address of a word goes to the top of the word
    always_comb begin
        adc_pkg::adc_addr_t byte_addr;
        rd_word = '0;
        for (int i = 0; i < host_pkg::WORD_BYTES; i++) begin
            byte_addr = adc_pkg::adc_addr_t'(rd_addr * host_pkg::WORD_BYTES + i);
            rd_word[host_pkg::WORD_W - 1 - i * adc_pkg::BYTE_W -: adc_pkg::BYTE_W] =
                mem[byte_addr];
        end
    end

    // rdata holds its last word while rd_en is low
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= rd_word;
        end
    end

endmodule

// File: logic/adc_capture_top.sv
// top level that connects the conversion trigger, SPI reader and frame buffer
`timescale 1ns/1ps

module adc_capture_top #(
    parameter int SCLK_DIV       = 2,
    parameter int TRIGGER_PERIOD = 700
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 trigger,
    input  logic                 periodic,
    output logic                 cs_n,
    output logic                 sclk,
    input  logic                 sdi,
    output logic                 drdy,
    input  logic                 rd_en,
    input  host_pkg::host_addr_t rd_addr,
    output host_pkg::host_word_t rdata
);

    logic               start;
    logic               frame_start;
    logic               byte_valid;
    adc_pkg::adc_byte_t byte_data;

    // a host pulse or a timer tick gives one start pulse either way
    conv_trigger #(
        .TRIGGER_PERIOD(TRIGGER_PERIOD)
    ) conv_trigger_inst (
        .clk     (clk),
        .resetn  (resetn),
        .trigger (trigger),
        .periodic(periodic),
        .start   (start)
    );

    adc_spi_reader #(
        .SCLK_DIV(SCLK_DIV)
    ) adc_spi_reader_inst (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .cs_n       (cs_n),
        .sclk       (sclk),
        .sdi        (sdi),
        .frame_start(frame_start),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    // the buffer takes every byte as it comes since there is no back-pressure
    frame_buffer frame_buffer_inst (
        .clk        (clk),
        .resetn     (resetn),
        .frame_start(frame_start),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .drdy       (drdy),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rdata      (rdata)
    );

endmodule

// File: sim/adc_model.sv
// converter model that shifts a loaded frame out on sdi MSB first
`timescale 1ns/1ps

module adc_model (
    input  logic                                            cs_n,
    input  logic                                            sclk,
    input  logic [adc_pkg::FRAME_BYTES*adc_pkg::BYTE_W-1:0] frame_data,
    output logic                                            sdi
);

    localparam int FRAME_BITS = adc_pkg::FRAME_BYTES * adc_pkg::BYTE_W;

    logic [FRAME_BITS-1:0] shift_q = '0;
    logic                  bit_q   = 1'b0;

    // the frame is latched when chip select falls while sclk idles high
    always @(negedge cs_n or negedge sclk) begin
        if (!cs_n && sclk) begin
            shift_q <= frame_data;
        end else if (!cs_n) begin
            // a new bit goes out on each falling edge and is stable by the next rising edge
            bit_q   <= shift_q[FRAME_BITS-1];
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    assign sdi = bit_q;

endmodule

// File: sim/tb_adc_capture.sv
// table-driven testbench with LCG frame data, read checks and a timeout
`timescale 1ns/1ps

module tb_adc_capture;

    localparam int SCLK_DIV       = 2;
    localparam int TRIGGER_PERIOD = 1100;
    localparam int FRAME_BITS     = adc_pkg::FRAME_BYTES * adc_pkg::BYTE_W;
    localparam int NUM_WORDS      = adc_pkg::FRAME_BYTES / host_pkg::WORD_BYTES;
    localparam int NUM_ROWS       = 3;
    localparam int FRAME_WAIT     = 2 * TRIGGER_PERIOD;

    // mode 0 is a host trigger, 1 is periodic, 2 adds a host retrigger mid-frame
    typedef struct packed {
        logic [1:0]           mode;
        logic [3:0]           frames;
        host_pkg::host_addr_t first_addr;
    } row_t;

    logic                  clk;
    logic                  resetn;
    logic                  trigger;
    logic                  periodic;
    logic                  cs_n;
    logic                  sclk;
    logic                  sdi;
    logic                  drdy;
    logic                  rd_en;
    host_pkg::host_addr_t  rd_addr;
    host_pkg::host_word_t  rdata;
    logic [FRAME_BITS-1:0] frame_data;
    adc_pkg::adc_byte_t    exp_bytes [adc_pkg::FRAME_BYTES];
    row_t                  rows [NUM_ROWS];
    logic [31:0]           lcg_state   = 32'd63;
    int                    errors      = 0;
    int                    drdy_count  = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 1000000;
    logic                  drdy_q      = 1'b0;

    adc_capture_top #(
        .SCLK_DIV      (SCLK_DIV),
        .TRIGGER_PERIOD(TRIGGER_PERIOD)
    ) adc_capture_top_inst (
        .clk     (clk),
        .resetn  (resetn),
        .trigger (trigger),
        .periodic(periodic),
        .cs_n    (cs_n),
        .sclk    (sclk),
        .sdi     (sdi),
        .drdy    (drdy),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rdata   (rdata)
    );

    adc_model adc_model_inst (
        .cs_n      (cs_n),
        .sclk      (sclk),
        .frame_data(frame_data),
        .sdi       (sdi)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // drdy is watched on the falling edge where it is stable
    always @(negedge clk) begin
        if (drdy) begin
            drdy_count = drdy_count + 1;
            assert (cs_n) else begin
                $display("error: %0t chip select was still low when drdy pulsed", $time);
                errors = errors + 1;
            end
        end
        assert (!(drdy && drdy_q)) else begin
            $display("error: %0t drdy stayed high for more than one cycle", $time);
            errors = errors + 1;
        end
        drdy_q = drdy;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // the first byte of each group of four is shifted in first and ends on top
    function automatic host_pkg::host_word_t expected_word(input host_pkg::host_addr_t addr);
        host_pkg::host_word_t word;
        word = '0;
        for (int i = 0; i < host_pkg::WORD_BYTES; i++) begin
            word = {word[host_pkg::WORD_W-adc_pkg::BYTE_W-1:0],
                    exp_bytes[int'(addr) * host_pkg::WORD_BYTES + i]};
        end
        return word;
    endfunction

    task automatic load_frame();
        @(posedge clk);
        for (int i = 0; i < adc_pkg::FRAME_BYTES; i++) begin
            lcg_state = lcg_step(lcg_state);
            exp_bytes[i] = lcg_state[23:16];
            frame_data[FRAME_BITS-1-i*adc_pkg::BYTE_W -: adc_pkg::BYTE_W] <= lcg_state[23:16];
        end
    endtask

    task automatic pulse_trigger();
        @(posedge clk);
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
    endtask

    task automatic check_word(input host_pkg::host_addr_t addr);
        assert (rdata == expected_word(addr)) else begin
            $display("error: %0t word %0d read %h expected %h",
                     $time, addr, rdata, expected_word(addr));
            errors = errors + 1;
        end
    endtask

    task automatic read_word(input host_pkg::host_addr_t addr);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        check_word(addr);
    endtask

    task automatic wait_frame();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!drdy && waited < FRAME_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (drdy) else begin
            $display("no drdy arrived within %0d cycles at %0t", FRAME_WAIT, $time);
            errors = errors + 1;
        end
    endtask

    initial begin
        int err_start;
        int count_start;
        int failed_tests;
        host_pkg::host_addr_t last_addr;
        $timeformat(-9, 0, " ns", 0);
        failed_tests = 0;
        resetn     = 1'b0;
        trigger    = 1'b0;
        periodic   = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        frame_data = '0;
        rows[0] = '{mode: 2'd0, frames: 4'd1, first_addr: 3'd0};
        rows[1] = '{mode: 2'd1, frames: 4'd2, first_addr: 3'd3};
        rows[2] = '{mode: 2'd2, frames: 4'd1, first_addr: 3'd5};
        cycle_limit = 2000;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit = cycle_limit + int'(rows[r].frames) * 1100 * 2;
        end

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        assert (cs_n && sclk && !drdy && rdata == '0) else begin
            $display("error: %0t after reset cs_n=%b sclk=%b drdy=%b rdata=%h",
                     $time, cs_n, sclk, drdy, rdata);
            errors = errors + 1;
        end
        $display("test 1 reset state: %s", (errors == 0) ? "ok" : "errors");
        failed_tests = (errors == 0) ? 0 : 1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_start   = errors;
            count_start = drdy_count;
            for (int f = 0; f < int'(rows[r].frames); f++) begin
                load_frame();
                if (rows[r].mode != 2'd1) begin
                    pulse_trigger();
                end else if (f == 0) begin
                    @(posedge clk);
                    periodic <= 1'b1;
                end
                if (rows[r].mode == 2'd2) begin
                    repeat (300) @(posedge clk);
                    pulse_trigger();
                end
                wait_frame();
                for (int k = 0; k < NUM_WORDS; k++) begin
                    read_word(rows[r].first_addr + host_pkg::host_addr_t'(k));
                end
                // with rd_en low a new address must not reach rdata
                last_addr = rows[r].first_addr + host_pkg::host_addr_t'(NUM_WORDS - 1);
                @(posedge clk);
                rd_addr <= last_addr + 3'd4;
                @(posedge clk);
                @(negedge clk);
                check_word(last_addr);
            end
            @(posedge clk);
            periodic <= 1'b0;
            repeat (40) @(negedge clk);
            assert (drdy_count - count_start == int'(rows[r].frames)) else begin
                $display("error: %0t saw %0d drdy pulses where %0d frames were expected",
                         $time, drdy_count - count_start, rows[r].frames);
                errors = errors + 1;
            end
            assert (cs_n) else begin
                $display("error: %0t chip select is low after the last frame", $time);
                errors = errors + 1;
            end
            $display("test %0d mode %0d with %0d frames: %s", r + 2, rows[r].mode,
                     rows[r].frames, (errors == err_start) ? "ok" : "errors");
            if (errors != err_start) begin
                failed_tests++;
            end
        end

        $display("summary: %0d tests, %0d with errors, %0d check errors",
                 NUM_ROWS + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/adc_pkg.sv
logic/host_pkg.sv
logic/conv_trigger.sv
logic/adc_spi_reader.sv
logic/frame_buffer.sv
logic/adc_capture_top.sv
sim/adc_model.sv
sim/tb_adc_capture.sv

// File: Makefile
# Verilator build and run of the ADC capture testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_capture
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# the run counts as passed only if the pass line shows up in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
